// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------------------------
    // Instruction word views
    // ------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    // Same 32 bits, R-type or I-type layout
    typedef union packed {
        rv_r_t r;
        rv_i_t i;
    } rv_instr_u;

    // ------------------------------------------------
    // Opcodes and function codes
    // ------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD  = 3'b000;   // also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;   // also SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // SUB, SRA, SRAI

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } rv_alu_op_e;

endpackage

// File: design/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // ------------------------------------------------
    // Decoded control
    // ------------------------------------------------
    typedef struct packed {
        logic [4:0]             rd;
        logic [4:0]             rs1;        // zero when unused
        logic [4:0]             rs2;        // zero when unused
        rv_isa_pkg::rv_alu_op_e alu_op;
        logic                   use_imm;
        logic                   reg_write;
        logic [31:0]            imm;
    } rv_ctrl_t;

    // ------------------------------------------------
    // Stage records
    // ------------------------------------------------
    typedef struct packed {
        logic        valid;
        rv_ctrl_t    ctrl;
        logic [31:0] reg_data1;
        logic [31:0] reg_data2;
    } rv_ex_t;

    // ALU2 and write stage, reg_write already qualified by valid
    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic [4:0]  rd;
        logic [31:0] data;
    } rv_res_t;

    // Retirement record on the writeback port
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } rv_wb_t;

endpackage

// File: design/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
#(
    parameter int NUM_REGS = 32
)
(
    input  rv_isa_pkg::rv_instr_u  i_instr,
    output rv_pipe_pkg::rv_ctrl_t  o_ctrl,
    output logic                   o_legal
);
    import rv_isa_pkg::*;

    logic [31:0] raw;
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic        op_ok;

    assign raw    = i_instr;
    assign funct7 = i_instr.r.funct7;
    assign funct3 = i_instr.r.funct3;

    function automatic logic in_range(input logic [4:0] idx);
        return int'(idx) < NUM_REGS;
    endfunction

    // Shared by register and immediate forms
    function automatic rv_alu_op_e base_op(
        input logic [2:0] f3,
        input logic       sub,
        input logic       arith
    );
        rv_alu_op_e op;
        case (f3)
            F3_ADD:  op = sub ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = arith ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb
    begin
        o_ctrl    = '0;
        op_ok     = 1'b0;
        o_ctrl.rd = i_instr.r.rd;
        case (i_instr.r.opcode)
            OPC_OP:
            begin
                o_ctrl.rs1    = i_instr.r.rs1;
                o_ctrl.rs2    = i_instr.r.rs2;
                o_ctrl.alu_op = base_op(funct3, funct7 == F7_ALT, funct7 == F7_ALT);
                // Alternate funct7 only on ADD/SUB and SRL/SRA
                op_ok = (funct7 == F7_BASE) ||
                        ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SRL)));
            end
            OPC_OP_IMM:
            begin
                o_ctrl.rs1     = i_instr.i.rs1;
                o_ctrl.use_imm = 1'b1;
                o_ctrl.alu_op  = base_op(funct3, 1'b0, i_instr.i.imm12[11:5] == F7_ALT);
                o_ctrl.imm     = {{20{i_instr.i.imm12[11]}}, i_instr.i.imm12};
                op_ok          = 1'b1;
                if ((funct3 == F3_SLL) || (funct3 == F3_SRL))
                begin
                    o_ctrl.imm = {27'd0, i_instr.i.imm12[4:0]};   // shamt only
                    op_ok = (i_instr.i.imm12[11:5] == F7_BASE) ||
                            ((funct3 == F3_SRL) && (i_instr.i.imm12[11:5] == F7_ALT));
                end
            end
            OPC_LUI:
            begin
                o_ctrl.use_imm = 1'b1;
                o_ctrl.alu_op  = ALU_PASS_B;
                o_ctrl.imm     = {raw[31:12], 12'd0};
                op_ok          = 1'b1;
            end
            default: op_ok = 1'b0;   // bubble
        endcase

        o_legal = op_ok && in_range(o_ctrl.rd) && in_range(o_ctrl.rs1) &&
                  in_range(o_ctrl.rs2);
        o_ctrl.reg_write = o_legal;
    end

    // SRAI selector bits must not leak into the shift amount
    always_comb
    begin
        if (o_legal && o_ctrl.use_imm &&
            (o_ctrl.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}))
        begin
            assert (o_ctrl.imm[31:5] == 27'd0)
                else $error("shift immediate has bits above 4 set");
        end
    end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
#(
    parameter int NUM_REGS = 32
)
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [4:0]  i_rs1,
    input  logic [4:0]  i_rs2,
    input  logic        i_we,
    input  logic [4:0]  i_rd,
    input  logic [31:0] i_wdata,
    output logic [31:0] o_rdata1,
    output logic [31:0] o_rdata2
);

    localparam int IDX_W = $clog2(NUM_REGS);

    logic [31:0] regs [NUM_REGS];

    // x0 is cleared on reset and never written
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int k = 0; k < NUM_REGS; k++)
            begin
                regs[k] <= '0;
            end
        end
        else if (i_we && (i_rd != 5'd0) && (int'(i_rd) < NUM_REGS))
        begin
            regs[i_rd[IDX_W-1:0]] <= i_wdata;
        end
    end

    // No write-through, the hazard echo covers same-cycle writes
    assign o_rdata1 = (int'(i_rs1) < NUM_REGS) ? regs[i_rs1[IDX_W-1:0]] : '0;
    assign o_rdata2 = (int'(i_rs2) < NUM_REGS) ? regs[i_rs2[IDX_W-1:0]] : '0;

    assert property (@(posedge i_clk) disable iff (i_rst) i_we |-> (int'(i_rd) < NUM_REGS))
        else $error("register write to index %0d beyond NUM_REGS", i_rd);

endmodule

// File: design/rv_hazard.sv
`timescale 1ns/1ps

module rv_hazard
(
    input  logic                  i_clk,
    input  logic [4:0]            i_alu_rs1,
    input  logic [4:0]            i_alu_rs2,
    input  rv_pipe_pkg::rv_res_t  i_alu2,
    input  rv_pipe_pkg::rv_res_t  i_write,
    input  logic [31:0]           i_reg_data1,
    input  logic [31:0]           i_reg_data2,
    output logic [31:0]           o_data1,
    output logic [31:0]           o_data2
);
    import rv_pipe_pkg::*;

    rv_res_t    echo_q;
    logic [3:0] sel1;     // {regfile, echo, write, alu2}
    logic [3:0] sel2;

    // Write stage one cycle later
    always_ff @(posedge i_clk)
    begin
        echo_q <= i_write;
    end

    // ------------------------------------------------
    // Source selection, youngest producer first
    // ------------------------------------------------
    function automatic logic [3:0] pick_source(
        input logic [4:0] rs,
        input rv_res_t    alu2,
        input rv_res_t    wr,
        input rv_res_t    echo
    );
        logic       hit_alu2;
        logic       hit_wr;
        logic       hit_echo;
        logic [3:0] sel;
        hit_alu2 = alu2.reg_write && (rs != 5'd0) && (rs == alu2.rd);
        hit_wr   = wr.reg_write   && (rs != 5'd0) && (rs == wr.rd);
        hit_echo = echo.reg_write && (rs != 5'd0) && (rs == echo.rd);
        sel[0] = hit_alu2;
        sel[1] = hit_wr && !hit_alu2;
        sel[2] = hit_echo && !hit_alu2 && !hit_wr;
        sel[3] = !(hit_alu2 || hit_wr || hit_echo);   // no producer in flight
        return sel;
    endfunction

    assign sel1 = pick_source(i_alu_rs1, i_alu2, i_write, echo_q);
    assign sel2 = pick_source(i_alu_rs2, i_alu2, i_write, echo_q);

    assign o_data1 = ({32{sel1[0]}} & i_alu2.data)  |
                     ({32{sel1[1]}} & i_write.data) |
                     ({32{sel1[2]}} & echo_q.data)  |
                     ({32{sel1[3]}} & i_reg_data1);

    assign o_data2 = ({32{sel2[0]}} & i_alu2.data)  |
                     ({32{sel2[1]}} & i_write.data) |
                     ({32{sel2[2]}} & echo_q.data)  |
                     ({32{sel2[3]}} & i_reg_data2);

    // Exactly one source drives each operand every cycle
    assert property (@(posedge i_clk) $onehot(sel1) && $onehot(sel2))
        else $error("forwarding select not one-hot: %b %b", sel1, sel2);

endmodule

// File: design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
(
    input  rv_isa_pkg::rv_alu_op_e  i_op,
    input  logic [31:0]             i_a,
    input  logic [31:0]             i_b,
    output logic [31:0]             o_result
);
    import rv_isa_pkg::*;

    logic [4:0]  shamt;
    logic        lt_signed;
    logic        lt_unsigned;

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb
    begin
        case (i_op)
            ALU_ADD:
                o_result = i_a + i_b;
            ALU_SUB:
                o_result = i_a - i_b;
            ALU_AND:
                o_result = i_a & i_b;
            ALU_OR:
                o_result = i_a | i_b;
            ALU_XOR:
                o_result = i_a ^ i_b;
            ALU_SLT:
                o_result = {31'd0, lt_signed};
            ALU_SLTU:
                o_result = {31'd0, lt_unsigned};
            ALU_SLL:
                o_result = i_a << shamt;
            ALU_SRL:
                o_result = i_a >> shamt;
            ALU_SRA:
                o_result = $unsigned($signed(i_a) >>> shamt);   // sign fill
            ALU_PASS_B:
                o_result = i_b;   // LUI
            default:
                o_result = '0;
        endcase
    end

endmodule

// File: design/rv_pipeline.sv
`timescale 1ns/1ps

module rv_pipeline
#(
    parameter int NUM_REGS = 32
)
(
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_instr_valid,
    input  rv_isa_pkg::rv_instr_u  i_instr,
    output rv_pipe_pkg::rv_wb_t    o_wb
);
    import rv_pipe_pkg::*;

    // ID
    rv_ctrl_t    id_ctrl;
    logic        id_legal;
    logic [31:0] id_rdata1;
    logic [31:0] id_rdata2;

    // Stage registers
    rv_ex_t      ex_q;
    rv_res_t     alu2_q;
    rv_res_t     write_q;

    // EX
    logic [31:0] fwd_data1;
    logic [31:0] fwd_data2;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        reg_we;

    // ------------------------------------------------
    // Decode and register read
    // ------------------------------------------------
    rv_decode #(.NUM_REGS(NUM_REGS)) rv_decode_inst
    (
        .i_instr  (i_instr),
        .o_ctrl   (id_ctrl),
        .o_legal  (id_legal)
    );

    assign reg_we = write_q.valid && write_q.reg_write;

    rv_regfile #(.NUM_REGS(NUM_REGS)) rv_regfile_inst
    (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs1     (id_ctrl.rs1),
        .i_rs2     (id_ctrl.rs2),
        .i_we      (reg_we),
        .i_rd      (write_q.rd),
        .i_wdata   (write_q.data),
        .o_rdata1  (id_rdata1),
        .o_rdata2  (id_rdata2)
    );

    // ------------------------------------------------
    // Execute
    // ------------------------------------------------
    rv_hazard rv_hazard_inst
    (
        .i_clk        (i_clk),
        .i_alu_rs1    (ex_q.ctrl.rs1),
        .i_alu_rs2    (ex_q.ctrl.rs2),
        .i_alu2       (alu2_q),
        .i_write      (write_q),
        .i_reg_data1  (ex_q.reg_data1),
        .i_reg_data2  (ex_q.reg_data2),
        .o_data1      (fwd_data1),
        .o_data2      (fwd_data2)
    );

    assign alu_b = ex_q.ctrl.use_imm ? ex_q.ctrl.imm : fwd_data2;

    rv_alu rv_alu_inst
    (
        .i_op      (ex_q.ctrl.alu_op),
        .i_a       (fwd_data1),
        .i_b       (alu_b),
        .o_result  (alu_result)
    );

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            ex_q    <= '0;
            alu2_q  <= '0;
            write_q <= '0;
        end
        else
        begin
            ex_q.valid     <= i_instr_valid && id_legal;   // illegal becomes a bubble
            ex_q.ctrl      <= id_ctrl;
            ex_q.reg_data1 <= id_rdata1;
            ex_q.reg_data2 <= id_rdata2;

            alu2_q.valid     <= ex_q.valid;
            alu2_q.reg_write <= ex_q.valid && ex_q.ctrl.reg_write;
            alu2_q.rd        <= ex_q.ctrl.rd;
            alu2_q.data      <= alu_result;

            write_q <= alu2_q;
        end
    end

    // x0 writes retire silently
    assign o_wb.valid = reg_we && (write_q.rd != 5'd0);
    assign o_wb.rd    = write_q.rd;
    assign o_wb.data  = write_q.data;

endmodule

// File: bench/rv_pipeline_tb.sv
`timescale 1ns/1ps

module rv_pipeline_tb;
    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int N_DIRECTED   = 80;
    localparam int N_RANDOM     = 3000;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + N_DIRECTED + N_RANDOM + 50) * CLK_PERIOD;

    logic                  i_clk = 1'b0;
    logic                  i_rst;
    logic                  instr_valid;
    rv_isa_pkg::rv_instr_u instr;
    rv_wb_t                wb;

    rv_wb_t                exp_q [$];        // one entry per issue slot
    logic [31:0]           model_regs [32];
    logic [31:0]           rng_state = 32'hcd19956c;
    int                    errors = 0;

    rv_pipeline #(.NUM_REGS(32)) rv_pipeline_inst
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .o_wb           (wb)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Mostly x0..x3 so that dependencies stay frequent
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return (r[31:30] != 2'b00) ? {3'd0, r[29:28]} : r[27:23];
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want)
        begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------
    // Reference model, in program order
    // --------------------------------------------------
    task automatic model_issue(input logic vld, input logic [31:0] w);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] fill;
        logic [31:0] res;
        logic        is_imm;
        logic        ok;
        rv_wb_t      rec;
        rd     = w[11:7];
        f3     = w[14:12];
        f7     = w[31:25];
        a      = model_regs[w[19:15]];
        is_imm = (w[6:0] == 7'b0010011);
        b      = is_imm ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        fill   = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0;   // sign bits shifted in
        ok     = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd5) || ((f3 == 3'd0) && !is_imm)));
        if (is_imm && (f3 != 3'd1) && (f3 != 3'd5))
            ok = 1'b1;   // upper bits are plain immediate
        case (f3)
            3'd0:    res = (!is_imm && (f7 == 7'h20)) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'd3:    res = {31'd0, a < b};
            3'd4:    res = a ^ b;
            3'd5:    res = (f7 == 7'h20) ? ((a >> b[4:0]) | fill) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == 7'b0110111)
        begin
            res = {w[31:12], 12'd0};
            ok  = 1'b1;
        end
        else if ((w[6:0] != 7'b0110011) && !is_imm)
        begin
            ok = 1'b0;
        end
        rec.valid = vld && ok && (rd != 5'd0);
        rec.rd    = rd;
        rec.data  = res;
        if (rec.valid)
            model_regs[rd] = res;
        exp_q.push_back(rec);
    endtask

    task automatic issue(input logic vld, input logic [31:0] w);
        @(posedge i_clk);
        instr_valid <= vld;
        instr       <= w;
        model_issue(vld, w);
    endtask

    task automatic issue_random();
        logic [31:0] r;
        logic [31:0] v;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = next_rand();
        v   = next_rand();
        f7  = (r[24] && ((r[27:25] == 3'd0) || (r[27:25] == 3'd5))) ? 7'h20 : 7'h00;
        imm = v[31:20];
        if ((r[27:25] == 3'd1) || (r[27:25] == 3'd5))
            imm[11:5] = (r[27:25] == 3'd5) ? f7 : 7'h00;   // SLLI, SRLI, SRAI
        if (r[31:28] < 4'd6)
            issue(1'b1, enc_r(f7, r[27:25], pick_reg(), pick_reg(), pick_reg()));
        else if (r[31:28] < 4'd11)
            issue(1'b1, enc_i(r[27:25], pick_reg(), pick_reg(), imm));
        else if (r[31:28] < 4'd13)
            issue(1'b1, {v[31:12], pick_reg(), 7'b0110111});
        else if (r[31:28] == 4'd13)
            issue(1'b1, {v[31:7], r[24] ? 7'b0000011 : 7'b1100011});   // load or branch
        else if (r[31:28] == 4'd14)
            issue(1'b1, enc_r(7'h01, r[27:25], pick_reg(), pick_reg(), pick_reg()));
        else
            issue(1'b0, v);
    endtask

    // Writeback lags issue by three edges
    always @(negedge i_clk)
    begin : wb_check
        rv_wb_t want;
        if (exp_q.size() < 4)
        begin
            check_value("idle o_wb.valid", {31'd0, wb.valid}, 32'd0);
        end
        else
        begin
            want = exp_q.pop_front();
            check_value("o_wb.valid", {31'd0, wb.valid}, {31'd0, want.valid});
            if (want.valid)
            begin
                check_value("o_wb.rd", {27'd0, wb.rd}, {27'd0, want.rd});
                check_value("o_wb.data", wb.data, want.data);
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial
    begin
        i_rst       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int k = 0; k < 32; k++)
            model_regs[k] = 32'd0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;

        for (int k = 0; k < 32; k++)
            issue(1'b1, enc_i(3'd0, k[4:0], k[4:0], 12'd0));   // all zero after reset

        issue(1'b1, enc_i(3'd0, 5'd5, 5'd0, 12'h123));
        issue(1'b1, enc_i(3'd0, 5'd5, 5'd5, 12'h801));
        issue(1'b1, enc_r(7'h00, 3'd0, 5'd6, 5'd5, 5'd5));
        issue(1'b1, enc_r(7'h20, 3'd0, 5'd7, 5'd6, 5'd5));
        // Reader at distance 1 to 4
        for (int d = 1; d <= 4; d++)
        begin
            issue(1'b1, enc_i(3'd0, 5'd10, 5'd10, 12'h011));
            repeat (d - 1)
                issue(1'b1, enc_i(3'd4, 5'd11, 5'd11, 12'h0f0));
            issue(1'b1, enc_r(7'h00, 3'd6, 5'd12, 5'd10, 5'd0));
        end
        for (int v = 1; v <= 3; v++)
            issue(1'b1, enc_i(3'd0, 5'd13, 5'd0, v[11:0]));   // youngest wins
        issue(1'b1, enc_r(7'h00, 3'd0, 5'd14, 5'd13, 5'd13));
        issue(1'b1, enc_i(3'd0, 5'd0, 5'd5, 12'h7ff));
        issue(1'b1, enc_r(7'h00, 3'd6, 5'd15, 5'd0, 5'd0));
        issue(1'b0, enc_i(3'd0, 5'd16, 5'd0, 12'h055));
        issue(1'b1, 32'h0000_2083);
        issue(1'b1, enc_r(7'h00, 3'd0, 5'd16, 5'd16, 5'd13));
        issue(1'b1, {20'h80000, 5'd18, 7'b0110111});
        issue(1'b1, enc_i(3'd2, 5'd19, 5'd18, 12'd0));
        issue(1'b1, enc_i(3'd3, 5'd20, 5'd18, 12'hfff));
        issue(1'b1, enc_i(3'd5, 5'd21, 5'd18, 12'h404));
        issue(1'b1, enc_r(7'h00, 3'd5, 5'd22, 5'd18, 5'd21));

        for (int n = 0; n < N_RANDOM; n++)
            issue_random();
        repeat (4)
            issue(1'b0, 32'd0);
        @(negedge i_clk);

        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

endmodule

// File: all.f
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_hazard.sv
design/rv_alu.sv
design/rv_pipeline.sv
bench/rv_pipeline_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := rv_pipeline_tb
FILELIST := all.f
OBJ_DIR  := obj_dir
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
